//--- nms_pkg.sv
package nms_pkg;

    // Pixel format
    localparam int pixel_bits = 8;

    // Image geometry, counted in pixels
    localparam int img_width  = 16;
    localparam int img_height = 12;
    localparam int pixel_count = img_width * img_height;

    // Two full rows plus three pixels hold a 3x3 neighbourhood
    localparam int window_len = 2 * img_width + 3;

    // Depth of both the input and the output FIFO
    localparam int fifo_depth = 16;

    // Suppressor FSM
    typedef enum logic [1:0] {
        st_prologue,
        st_suppression,
        st_output
    } nms_state_t;

endpackage

//--- pixel_fifo_if.sv
`timescale 1ns/1ps

interface pixel_fifo_if import nms_pkg::*; ();

    // Write side
    logic                  wr_en;
    logic [pixel_bits-1:0] din;
    logic                  full;

    // Read side, dout shows the head word while empty is low
    logic                  rd_en;
    logic [pixel_bits-1:0] dout;
    logic                  empty;

    // Seen from the modules around the FIFO
    modport writer (output wr_en, output din, input full);
    modport reader (output rd_en, input dout, input empty);

    // Seen from the FIFO itself
    modport buffer_write (input wr_en, input din, output full);
    modport buffer_read (input rd_en, output dout, output empty);

endinterface

//--- pixel_fifo.sv
`timescale 1ns/1ps

module pixel_fifo import nms_pkg::*; #(
    parameter int depth = fifo_depth
) (
    input logic               clock,
    input logic               reset,
    pixel_fifo_if.buffer_write buffer_write,
    pixel_fifo_if.buffer_read  buffer_read
);

    logic [pixel_bits-1:0]        mem [depth];
    logic [$clog2(depth)-1:0]     wr_ptr;
    logic [$clog2(depth)-1:0]     rd_ptr;
    logic [$clog2(depth + 1)-1:0] count;
    logic                         do_write;
    logic                         do_read;

    assign buffer_write.full = (int'(count) == depth);
    assign buffer_read.empty = (count == '0);

    // Head word falls through without a read cycle
    assign buffer_read.dout = mem[rd_ptr];

    assign do_write = buffer_write.wr_en && !buffer_write.full;
    assign do_read  = buffer_read.rd_en && !buffer_read.empty;

    always_ff @(posedge clock) begin
        if (do_write) begin
            mem[wr_ptr] <= buffer_write.din;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= (int'(wr_ptr) == depth - 1) ? '0 : wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= (int'(rd_ptr) == depth - 1) ? '0 : rd_ptr + 1'b1;
            end
            // Simultaneous push and pop leave the count alone
            case ({do_write, do_read})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Producer must respect full
    overflow_check: assert property (
        @(posedge clock) disable iff (reset)
        !(buffer_write.wr_en && buffer_write.full)
    ) else $error("pixel_fifo write while full");

    // Consumer must respect empty
    underflow_check: assert property (
        @(posedge clock) disable iff (reset)
        !(buffer_read.rd_en && buffer_read.empty)
    ) else $error("pixel_fifo read while empty");

endmodule

//--- non_maximum_suppressor.sv
`timescale 1ns/1ps

module non_maximum_suppressor import nms_pkg::*; (
    input logic          clock,
    input logic          reset,
    pixel_fifo_if.reader pixels_in,
    pixel_fifo_if.writer pixels_out
);

    nms_state_t state;
    nms_state_t next_state;

    // Oldest pixel at index 0, newest at the far end
    logic [0:window_len-1][pixel_bits-1:0] window;
    logic                                  shift_en;
    logic [pixel_bits-1:0]                 shift_in;

    logic [$clog2(img_width + 3)-1:0]   prologue_count;
    logic [$clog2(img_width + 3)-1:0]   prologue_count_c;
    logic [$clog2(img_width)-1:0]       col;
    logic [$clog2(img_width)-1:0]       col_c;
    logic [$clog2(img_height + 1)-1:0]  row;
    logic [$clog2(img_height + 1)-1:0]  row_c;
    logic [$clog2(pixel_count + 1)-1:0] pixels_read;
    logic [$clog2(pixel_count + 1)-1:0] pixels_read_c;

    logic [pixel_bits-1:0] result;
    logic [pixel_bits-1:0] result_c;

    // 3x3 neighbourhood around the centre pixel
    logic [pixel_bits-1:0] px_nw, px_n, px_ne;
    logic [pixel_bits-1:0] px_w, px_c, px_e;
    logic [pixel_bits-1:0] px_sw, px_s, px_se;

    // One extra bit so the pair sums cannot wrap
    logic [pixel_bits:0] sum_ns, sum_we, sum_nwse, sum_nesw;

    logic                  border;
    logic                  padding;
    logic [pixel_bits-1:0] suppressed;

    assign px_nw = window[0];
    assign px_n  = window[1];
    assign px_ne = window[2];
    assign px_w  = window[img_width];
    assign px_c  = window[img_width + 1];
    assign px_e  = window[img_width + 2];
    assign px_sw = window[2 * img_width];
    assign px_s  = window[2 * img_width + 1];
    assign px_se = window[2 * img_width + 2];

    assign sum_ns   = {1'b0, px_n}  + {1'b0, px_s};
    assign sum_we   = {1'b0, px_w}  + {1'b0, px_e};
    assign sum_nwse = {1'b0, px_nw} + {1'b0, px_se};
    assign sum_nesw = {1'b0, px_ne} + {1'b0, px_sw};

    assign border = (row == '0) || (int'(row) == img_height - 1) ||
                    (col == '0) || (int'(col) == img_width - 1);

    // Whole frame consumed, the rest of the window fills with zeros
    assign padding = (int'(pixels_read) == pixel_count);

    // Largest pair sum picks the direction, ties go to the earlier pair
    always_comb begin
        suppressed = '0;
        if (!border) begin
            if (sum_ns >= sum_we && sum_ns >= sum_nwse && sum_ns >= sum_nesw) begin
                if (px_c > px_w && px_c >= px_e) suppressed = px_c;
            end else if (sum_we >= sum_nwse && sum_we >= sum_nesw) begin
                if (px_c > px_n && px_c >= px_s) suppressed = px_c;
            end else if (sum_nwse >= sum_nesw) begin
                if (px_c > px_ne && px_c >= px_sw) suppressed = px_c;
            end else begin
                if (px_c > px_nw && px_c >= px_se) suppressed = px_c;
            end
        end
    end

    always_comb begin
        next_state       = state;
        prologue_count_c = prologue_count;
        col_c            = col;
        row_c            = row;
        pixels_read_c    = pixels_read;
        result_c         = result;
        shift_en         = 1'b0;
        shift_in         = pixels_in.dout;
        pixels_in.rd_en  = 1'b0;
        pixels_out.wr_en = 1'b0;
        pixels_out.din   = result;

        case (state)
            st_prologue: begin
                // Fill up to the first centre pixel
                if (!pixels_in.empty) begin
                    pixels_in.rd_en  = 1'b1;
                    shift_en         = 1'b1;
                    pixels_read_c    = pixels_read + 1'b1;
                    prologue_count_c = prologue_count + 1'b1;
                    if (int'(prologue_count) == img_width + 1) begin
                        next_state = st_suppression;
                    end
                end
            end

            st_suppression: begin
                if (padding || !pixels_in.empty) begin
                    shift_en = 1'b1;
                    if (padding) begin
                        shift_in = '0;
                    end else begin
                        pixels_in.rd_en = 1'b1;
                        pixels_read_c   = pixels_read + 1'b1;
                    end
                    result_c = suppressed;
                    // Centre moves on, row reaches img_height after the last pixel
                    if (int'(col) == img_width - 1) begin
                        col_c = '0;
                        row_c = row + 1'b1;
                    end else begin
                        col_c = col + 1'b1;
                    end
                    next_state = st_output;
                end
            end

            st_output: begin
                if (!pixels_out.full) begin
                    pixels_out.wr_en = 1'b1;
                    next_state       = st_suppression;
                    // Last result of the frame
                    if (int'(row) == img_height) begin
                        next_state       = st_prologue;
                        prologue_count_c = '0;
                        col_c            = '0;
                        row_c            = '0;
                        pixels_read_c    = '0;
                    end
                end
            end

            default: begin
                next_state = st_prologue;
            end
        endcase
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state          <= st_prologue;
            prologue_count <= '0;
            col            <= '0;
            row            <= '0;
            pixels_read    <= '0;
        end else begin
            state          <= next_state;
            prologue_count <= prologue_count_c;
            col            <= col_c;
            row            <= row_c;
            pixels_read    <= pixels_read_c;
        end
    end

    // Stale entries from the previous frame only ever reach border outputs
    always_ff @(posedge clock) begin
        result <= result_c;
        if (shift_en) begin
            window <= {window[1:window_len-1], shift_in};
        end
    end

    state_check: assert property (
        @(posedge clock) disable iff (reset)
        state inside {st_prologue, st_suppression, st_output}
    ) else $error("suppressor state out of range");

    // Back-pressure from the output FIFO must stall the FSM
    out_full_check: assert property (
        @(posedge clock) disable iff (reset)
        !(pixels_out.wr_en && pixels_out.full)
    ) else $error("suppressor wrote into a full output FIFO");

endmodule

//--- nms_filter_top.sv
`timescale 1ns/1ps

module nms_filter_top import nms_pkg::*; (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  in_wr_en,
    input  logic [pixel_bits-1:0] in_din,
    output logic                  in_full,
    input  logic                  out_rd_en,
    output logic [pixel_bits-1:0] out_dout,
    output logic                  out_empty
);

    pixel_fifo_if in_bus ();
    pixel_fifo_if out_bus ();

    // Outside writer feeds the input FIFO
    assign in_bus.wr_en = in_wr_en;
    assign in_bus.din   = in_din;
    assign in_full      = in_bus.full;

    // Outside reader drains the output FIFO
    assign out_bus.rd_en = out_rd_en;
    assign out_dout      = out_bus.dout;
    assign out_empty     = out_bus.empty;

    pixel_fifo #(
        .depth(fifo_depth)
    ) i_in_fifo (
        .clock       (clock),
        .reset       (reset),
        .buffer_write(in_bus.buffer_write),
        .buffer_read (in_bus.buffer_read)
    );

    non_maximum_suppressor i_suppressor (
        .clock     (clock),
        .reset     (reset),
        .pixels_in (in_bus.reader),
        .pixels_out(out_bus.writer)
    );

    pixel_fifo #(
        .depth(fifo_depth)
    ) i_out_fifo (
        .clock       (clock),
        .reset       (reset),
        .buffer_write(out_bus.buffer_write),
        .buffer_read (out_bus.buffer_read)
    );

endmodule

//--- nms_filter_tb.sv
`timescale 1ns/1ps

module nms_filter_tb import nms_pkg::*; ();

    localparam int frames          = 7;
    localparam int total_pixels    = frames * pixel_count;
    localparam int watchdog_cycles = frames * pixel_count * 20;

    logic                  clock;
    logic                  reset;
    logic                  in_wr_en;
    logic [pixel_bits-1:0] in_din;
    logic                  in_full;
    logic                  out_rd_en;
    logic [pixel_bits-1:0] out_dout;
    logic                  out_empty;

    // Every frame sent, kept for the reference model
    logic [pixel_bits-1:0] frame_mem [frames][pixel_count];

    // FIFO flags taken at the falling edge, where they are settled
    logic in_full_seen;
    logic out_empty_seen;

    // Set once back-pressure has filled the input FIFO
    bit in_full_reached = 1'b0;

    logic [pixel_bits-1:0] result_q [$];
    int                    write_count;
    int                    pop_count = 0;
    bit                    compare_done = 1'b0;

    nms_filter_top i_nms_filter_top (
        .clock    (clock),
        .reset    (reset),
        .in_wr_en (in_wr_en),
        .in_din   (in_din),
        .in_full  (in_full),
        .out_rd_en(out_rd_en),
        .out_dout (out_dout),
        .out_empty(out_empty)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    // Frames 4 and 5 run with write gaps and a slow reader
    function automatic bit stressed(input int frame);
        return (frame == 4) || (frame == 5);
    endfunction

    function automatic int neighbour(input int frame, input int index, input int dr, input int dc);
        return int'(frame_mem[frame][index + dr * img_width + dc]);
    endfunction

    function automatic int nms_expected(input int frame, input int index);
        int row;
        int col;
        int c, n, s, w, e, nw, ne, sw, se;
        int sums [4];
        int best;
        int d;
        bit keep;
        row = index / img_width;
        col = index % img_width;
        if (row == 0 || row == img_height - 1 || col == 0 || col == img_width - 1) begin
            return 0;
        end
        c  = neighbour(frame, index, 0, 0);
        n  = neighbour(frame, index, -1, 0);
        s  = neighbour(frame, index, 1, 0);
        w  = neighbour(frame, index, 0, -1);
        e  = neighbour(frame, index, 0, 1);
        nw = neighbour(frame, index, -1, -1);
        ne = neighbour(frame, index, -1, 1);
        sw = neighbour(frame, index, 1, -1);
        se = neighbour(frame, index, 1, 1);
        sums[0] = n + s;
        sums[1] = w + e;
        sums[2] = nw + se;
        sums[3] = ne + sw;
        // Only a strictly larger sum displaces an earlier one
        best = 0;
        for (d = 1; d < 4; d++) begin
            if (sums[d] > sums[best]) begin
                best = d;
            end
        end
        case (best)
            0:       keep = (c > w) && (c >= e);
            1:       keep = (c > n) && (c >= s);
            2:       keep = (c > ne) && (c >= sw);
            default: keep = (c > nw) && (c >= se);
        endcase
        return keep ? c : 0;
    endfunction

    task automatic check_value(input int actual, input int expected, input string what);
        if (actual != expected) begin
            $display("FAIL %0t: %s, got %0d, expected %0d", $time, what, actual, expected);
            $display("sim failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic build_frames();
        int f;
        int p;
        int row;
        int col;
        int value;
        for (f = 0; f < frames; f++) begin
            for (p = 0; p < pixel_count; p++) begin
                row = p / img_width;
                col = p % img_width;
                case (f)
                    1: begin
                        // Bright frame edge around a dim interior
                        if (row == 0 || row == img_height - 1 || col == 0 ||
                            col == img_width - 1) begin
                            value = 255;
                        end else begin
                            value = int'($urandom_range(0, 127));
                        end
                    end
                    2: value = ((col + 2 * row) / 2) * 10;
                    3: begin
                        // Equal horizontal and vertical peak pairs on a faint floor
                        if (row % 3 == 1 && (col % 4 == 1 || col % 4 == 2)) begin
                            value = 100;
                        end else if (col % 4 == 3 && row % 3 != 1) begin
                            value = 80;
                        end else begin
                            value = int'($urandom_range(0, 2));
                        end
                    end
                    5: value = int'($urandom_range(0, 3));
                    default: value = int'($urandom_range(0, 255));
                endcase
                frame_mem[f][p] = pixel_bits'(value);
            end
        end
    endtask

    initial begin
        void'($urandom(29));
        reset          = 1'b1;
        in_wr_en       = 1'b0;
        in_din         = '0;
        out_rd_en      = 1'b0;
        in_full_seen   = 1'b1;
        out_empty_seen = 1'b1;
        build_frames();
        repeat (16) @(posedge clock);
        // Both FIFOs come out of reset empty
        check_value(int'(in_full), 0, "in_full while reset is held");
        check_value(int'(out_empty), 1, "out_empty while reset is held");
        reset <= 1'b0;
        wait (compare_done);
        // Let any stray result surface before counting
        repeat (50) @(posedge clock);
        check_value(pop_count, total_pixels, "number of results after the last frame");
        check_value(int'(out_empty), 1, "output FIFO empty after the last frame");
        check_value(int'(in_full_reached), 1, "input FIFO full under back-pressure");
        $display("sim passed");
        $finish;
    end

    initial begin
        forever begin
            @(negedge clock);
            in_full_seen   = in_full;
            out_empty_seen = out_empty;
            if (in_full) begin
                in_full_reached = 1'b1;
            end
            if (out_rd_en) begin
                if (out_empty) begin
                    $display("Reader strobed out_rd_en at %0t while the output FIFO was empty",
                             $time);
                    $display("sim failed");
                    $fatal(1, "output FIFO underflow");
                end else begin
                    result_q.push_back(out_dout);
                    pop_count++;
                end
            end
        end
    end

    // Writer, never strobes twice in a row so full cannot rise under a strobe
    initial begin
        write_count = 0;
        @(negedge reset);
        forever begin
            @(posedge clock);
            if (in_wr_en) begin
                write_count++;
            end
            if (write_count < total_pixels && !in_full_seen && !in_wr_en &&
                !(stressed(write_count / pixel_count) && $urandom_range(0, 99) < 40)) begin
                in_wr_en <= 1'b1;
                in_din   <= frame_mem[write_count / pixel_count][write_count % pixel_count];
            end else begin
                in_wr_en <= 1'b0;
            end
        end
    end

    // Reader, same spacing rule against the empty flag
    initial begin
        @(negedge reset);
        forever begin
            @(posedge clock);
            if (!out_empty_seen && !out_rd_en &&
                !(stressed(pop_count / pixel_count) && $urandom_range(0, 99) < 75)) begin
                out_rd_en <= 1'b1;
            end else begin
                out_rd_en <= 1'b0;
            end
        end
    end

    initial begin : compare
        int                    checked;
        int                    frame;
        int                    index;
        logic [pixel_bits-1:0] got;
        checked = 0;
        while (checked < total_pixels) begin
            @(posedge clock);
            while (result_q.size() > 0 && checked < total_pixels) begin
                got   = result_q.pop_front();
                frame = checked / pixel_count;
                index = checked % pixel_count;
                check_value(int'(got), nms_expected(frame, index),
                            $sformatf("frame %0d row %0d col %0d", frame,
                                      index / img_width, index % img_width));
                checked++;
            end
        end
        compare_done = 1'b1;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clock);
        $display("The run timed out after %0d clock cycles", watchdog_cycles);
        $display("sim failed");
        $fatal(1, "timeout");
    end

endmodule

//--- nms_filter_top.f
nms_pkg.sv
pixel_fifo_if.sv
pixel_fifo.sv
non_maximum_suppressor.sv
nms_filter_top.sv
nms_filter_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module nms_filter_tb \
    -f nms_filter_top.f -o nms_sim \
    && ./obj_dir/nms_sim > sim.log 2>&1 \
    || echo "simulation build or run ended with an error" >> sim.log

cat sim.log

# A missing pass line counts as a failure too
! grep -q "sim failed" sim.log && grep -q "sim passed" sim.log && exit 0 || exit 1
